// File: rtl/vcache_event_decode.sv
// cache event classifier
module vcache_event_decode (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  vcache_op_pkg::cache_obs_s     cache_obs_i,
  input  vcache_op_pkg::dma_obs_s       dma_obs_i,
  input  vcache_op_pkg::fill_obs_s      fill_obs_i,
  output vcache_stat_pkg::stat_events_t events_o
);

  import vcache_op_pkg::*;
  import vcache_stat_pkg::*;

  logic         rsp;
  logic         ld;
  logic         st;
  logic         amo;
  logic         ld_sized;
  logic         st_masked;
  logic [1:0]   size;
  logic         sigext;
  logic [2:0]   mask_pop;
  logic         dma_go;
  logic         repl;
  logic         way_valid;
  logic         way_dirty;
  stat_events_t events_n;
  stat_events_t events_r;

  // a response leaves the cache when it is valid and taken
  assign rsp = cache_obs_i.v & cache_obs_i.yumi;

  assign ld  = rsp & cache_obs_i.decode.ld_op;
  assign st  = rsp & cache_obs_i.decode.st_op;
  assign amo = rsp & cache_obs_i.decode.atomic_op;

  // loads are sized only without the mask op, stores only with it
  assign ld_sized  = ld & ~cache_obs_i.decode.mask_op;
  assign st_masked = st & cache_obs_i.decode.mask_op;
  assign size      = cache_obs_i.decode.data_size;
  assign sigext    = cache_obs_i.decode.sigext_op;
  assign mask_pop  = 3'($countones(cache_obs_i.mask));

  assign dma_go = dma_obs_i.pkt_v & dma_obs_i.pkt_yumi;

  // fill address sent and done means a way is being replaced
  assign repl      = (fill_obs_i.dma_cmd == e_dma_send_fill_addr) & fill_obs_i.dma_done;
  assign way_valid = fill_obs_i.valid[fill_obs_i.chosen_way];
  assign way_dirty = fill_obs_i.dirty[fill_obs_i.chosen_way];

  always_comb begin
    events_n = '0;

    events_n[e_stat_ld]     = ld;
    events_n[e_stat_ld_lw]  = ld_sized & (size == 2'd2) & sigext;
    events_n[e_stat_ld_lwu] = ld_sized & (size == 2'd2) & ~sigext;
    events_n[e_stat_ld_lh]  = ld_sized & (size == 2'd1) & sigext;
    events_n[e_stat_ld_lhu] = ld_sized & (size == 2'd1) & ~sigext;
    events_n[e_stat_ld_lb]  = ld_sized & (size == 2'd0) & sigext;
    events_n[e_stat_ld_lbu] = ld_sized & (size == 2'd0) & ~sigext;

    events_n[e_stat_st]    = st;
    events_n[e_stat_sm_sw] = st_masked & (mask_pop == 3'd4);
    events_n[e_stat_sm_sh] = st_masked & (mask_pop == 3'd2);
    events_n[e_stat_sm_sb] = st_masked & (mask_pop == 3'd1); // pop 3 counts as st only

    events_n[e_stat_atomic]  = amo;
    events_n[e_stat_amoswap] = amo & (cache_obs_i.decode.amo_subop == e_amo_swap);
    events_n[e_stat_amoor]   = amo & (cache_obs_i.decode.amo_subop == e_amo_or);
    events_n[e_stat_amoadd]  = amo & (cache_obs_i.decode.amo_subop == e_amo_add);

    events_n[e_stat_miss_ld]  = ld & cache_obs_i.miss_v;
    events_n[e_stat_miss_st]  = st & cache_obs_i.miss_v;
    events_n[e_stat_miss_amo] = amo & cache_obs_i.miss_v;

    // per-cycle state of the response side
    events_n[e_stat_miss_cyc]      = cache_obs_i.miss_v & ~cache_obs_i.v;
    events_n[e_stat_idle_cyc]      = ~cache_obs_i.v & ~cache_obs_i.miss_v;
    events_n[e_stat_stall_rsp_cyc] = cache_obs_i.v & ~cache_obs_i.yumi;

    events_n[e_stat_dma_rd] = dma_go & ~dma_obs_i.write_not_read;
    events_n[e_stat_dma_wr] = dma_go & dma_obs_i.write_not_read;

    events_n[e_stat_repl_invalid] = repl & ~way_valid;
    events_n[e_stat_repl_valid]   = repl & way_valid & ~way_dirty;
    events_n[e_stat_repl_dirty]   = repl & way_valid & way_dirty;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      events_r <= '0;
    end else begin
      events_r <= events_n;
    end
  end

  assign events_o = events_r;

  // the cache decodes a single op kind per response
  op_kind_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_obs_i.v |-> $onehot0({cache_obs_i.decode.ld_op,
                                cache_obs_i.decode.st_op,
                                cache_obs_i.decode.atomic_op}));

endmodule

// File: rtl/vcache_op_pkg.sv
// cache observation types
`include "vcache_prof_defs.svh"

package vcache_op_pkg;

  // atomic subop as the cache decodes it
  typedef enum logic [1:0] {
    e_amo_swap  = 2'd0,
    e_amo_or    = 2'd1,
    e_amo_add   = 2'd2,
    e_amo_other = 2'd3
  } cache_amo_e;

  // miss unit dma commands
  typedef enum logic [2:0] {
    e_dma_nop             = 3'd0,
    e_dma_send_fill_addr  = 3'd1, // the only one counted
    e_dma_send_evict_addr = 3'd2,
    e_dma_get_fill_data   = 3'd3,
    e_dma_send_evict_data = 3'd4
  } dma_cmd_e;

  typedef struct packed {
    logic       ld_op;
    logic       st_op;
    logic       atomic_op;
    logic       mask_op;
    logic       sigext_op;
    logic [1:0] data_size; // 2 word, 1 half, 0 byte
    cache_amo_e amo_subop;
  } cache_decode_s;

  // response side of the cache pipeline
  typedef struct packed {
    logic                      v;
    logic                      yumi;
    logic                      miss_v;
    cache_decode_s             decode;
    logic [`VCACHE_MASK_W-1:0] mask;
  } cache_obs_s;

  typedef struct packed {
    logic pkt_v;
    logic pkt_yumi;
    logic write_not_read;
  } dma_obs_s;

  // miss unit view for replacement classes
  typedef struct packed {
    dma_cmd_e                   dma_cmd;
    logic                       dma_done;
    logic [`VCACHE_LG_WAYS-1:0] chosen_way;
    logic [`VCACHE_WAYS-1:0]    valid;
    logic [`VCACHE_WAYS-1:0]    dirty;
  } fill_obs_s;

endpackage

// File: rtl/vcache_prof_defs.svh
// cache profiler parameters
`ifndef VCACHE_PROF_DEFS_SVH
`define VCACHE_PROF_DEFS_SVH

// observed cache geometry
`define VCACHE_WAYS 8
`define VCACHE_LG_WAYS $clog2(`VCACHE_WAYS)
`define VCACHE_MASK_W 4 // byte mask of 32-bit data

// statistics
`define STAT_CNT_W 32
`define STAT_NUM 27

// axi4-lite bus and address map
`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32
`define STAT_CLEAR_ADDR 8'h80 // counters sit at index * 4 below this

`endif

// File: rtl/vcache_profiler.sv
// cache activity profiler
`include "vcache_prof_defs.svh"

module vcache_profiler (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  vcache_op_pkg::cache_obs_s  cache_obs_i,
  input  vcache_op_pkg::dma_obs_s    dma_obs_i,
  input  vcache_op_pkg::fill_obs_s   fill_obs_i,
  input  vcache_stat_pkg::axil_req_s axil_req_i,
  output vcache_stat_pkg::axil_rsp_s axil_rsp_o
);

  import vcache_stat_pkg::*;

  stat_events_t           events;
  stat_idx_e              rd_idx;
  logic [`STAT_CNT_W-1:0] rd_data;
  logic                   clear;

  vcache_event_decode event_decode_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cache_obs_i (cache_obs_i),
    .dma_obs_i   (dma_obs_i),
    .fill_obs_i  (fill_obs_i),
    .events_o    (events)
  );

  // counts land one cycle after the registered event
  vcache_stat_counters stat_counters_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .events_i  (events),
    .clear_i   (clear),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data)
  );

  vcache_stat_axil stat_axil_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .rd_idx_o   (rd_idx),
    .rd_data_i  (rd_data),
    .clear_o    (clear)
  );

endmodule

// File: rtl/vcache_stat_axil.sv
// axi4-lite statistics slave
`include "vcache_prof_defs.svh"

module vcache_stat_axil (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  vcache_stat_pkg::axil_req_s axil_req_i,
  output vcache_stat_pkg::axil_rsp_s axil_rsp_o,
  output vcache_stat_pkg::stat_idx_e rd_idx_o,
  input  logic [`STAT_CNT_W-1:0]     rd_data_i,
  output logic                       clear_o
);

  import vcache_stat_pkg::*;

  logic [`AXIL_ADDR_W-3:0] rd_word; // word index of the read address
  logic                    rd_ok;
  logic                    rd_accept;
  logic                    wr_ok;
  logic                    wr_accept;
  logic                    rvalid_r;
  logic [`AXIL_DATA_W-1:0] rdata_r;
  axil_resp_e              rresp_r;
  logic                    bvalid_r;
  axil_resp_e              bresp_r;
  logic                    clear_r;

  assign rd_word   = axil_req_i.araddr[`AXIL_ADDR_W-1:2];
  assign rd_ok     = rd_word < `STAT_NUM;
  assign rd_accept = axil_req_i.arvalid & ~rvalid_r; // one read in flight
  assign rd_idx_o  = stat_idx_e'(rd_word[$bits(stat_idx_e)-1:0]);

  // address and data must arrive together
  assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_r;
  assign wr_ok     = axil_req_i.awaddr == `STAT_CLEAR_ADDR;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
    end else if (rd_accept) begin
      rvalid_r <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_r <= 1'b0;
    end
  end

  // counter value is taken when the address is accepted
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_r <= rd_ok ? rd_data_i : '0;
      rresp_r <= rd_ok ? e_axil_okay : e_axil_slverr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
      clear_r  <= 1'b0;
    end else begin
      clear_r <= wr_accept & wr_ok; // bad address leaves counters alone
      if (wr_accept) begin
        bvalid_r <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      bresp_r <= wr_ok ? e_axil_okay : e_axil_slverr;
    end
  end

  always_comb begin
    axil_rsp_o.arready = ~rvalid_r;
    axil_rsp_o.rvalid  = rvalid_r;
    axil_rsp_o.rdata   = rdata_r;
    axil_rsp_o.rresp   = rresp_r;
    axil_rsp_o.awready = ~bvalid_r;
    axil_rsp_o.wready  = ~bvalid_r;
    axil_rsp_o.bvalid  = bvalid_r;
    axil_rsp_o.bresp   = bresp_r;
  end

  assign clear_o = clear_r;

  // read response holds until taken
  rsp_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_r && !axil_req_i.rready |=> rvalid_r && $stable(rdata_r) && $stable(rresp_r));

  // write response holds until taken
  rsp_b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_r && !axil_req_i.bready |=> bvalid_r && $stable(bresp_r));

endmodule

// File: rtl/vcache_stat_counters.sv
// statistics counter bank
`include "vcache_prof_defs.svh"

module vcache_stat_counters (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  vcache_stat_pkg::stat_events_t events_i,
  input  logic                          clear_i,
  input  vcache_stat_pkg::stat_idx_e    rd_idx_i,
  output logic [`STAT_CNT_W-1:0]        rd_data_o
);

  logic [`STAT_CNT_W-1:0] cnt_r [`STAT_NUM];

  // clear beats a same-cycle increment
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `STAT_NUM; i++) begin
      if (reset_i || clear_i) begin
        cnt_r[i] <= '0;
      end else if (events_i[i]) begin
        cnt_r[i] <= cnt_r[i] + 1; // wraps at 2^32
      end
    end
  end

  // indices past the last counter read as zero
  always_comb begin
    if (int'(rd_idx_i) < `STAT_NUM) begin
      rd_data_o = cnt_r[rd_idx_i];
    end else begin
      rd_data_o = '0;
    end
  end

endmodule

// File: rtl/vcache_stat_pkg.sv
// statistics and bus types
`include "vcache_prof_defs.svh"

package vcache_stat_pkg;

  // counter index, bus address is index * 4
  typedef enum logic [4:0] {
    e_stat_ld,
    e_stat_ld_lw,
    e_stat_ld_lwu,
    e_stat_ld_lh,
    e_stat_ld_lhu,
    e_stat_ld_lb,
    e_stat_ld_lbu,
    e_stat_st,
    e_stat_sm_sw,
    e_stat_sm_sh,
    e_stat_sm_sb,
    e_stat_atomic,
    e_stat_amoswap,
    e_stat_amoor,
    e_stat_amoadd,
    e_stat_miss_ld,
    e_stat_miss_st,
    e_stat_miss_amo,
    e_stat_miss_cyc,
    e_stat_idle_cyc,
    e_stat_stall_rsp_cyc,
    e_stat_dma_rd,
    e_stat_dma_wr,
    e_stat_repl_invalid,
    e_stat_repl_valid,
    e_stat_repl_dirty,
    e_stat_reserved // never fires
  } stat_idx_e;

  typedef logic [`STAT_NUM-1:0] stat_events_t; // one bit per counter

  typedef enum logic [1:0] {
    e_axil_okay   = 2'b00,
    e_axil_exokay = 2'b01,
    e_axil_slverr = 2'b10,
    e_axil_decerr = 2'b11
  } axil_resp_e;

  typedef struct packed {
    logic                    arvalid;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    rready;
    logic                    awvalid;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    wvalid;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic                    bready;
  } axil_req_s;

  typedef struct packed {
    logic                    arready;
    logic                    rvalid;
    logic [`AXIL_DATA_W-1:0] rdata;
    axil_resp_e              rresp;
    logic                    awready;
    logic                    wready;
    logic                    bvalid;
    axil_resp_e              bresp;
  } axil_rsp_s;

endpackage

// File: run_sim.sh
#!/bin/sh
# build the profiler testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_vcache_profiler -o vtb -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/vtb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// File: sim/tb_vcache_profiler.sv
// cache profiler testbench
`include "vcache_prof_defs.svh"

module tb_vcache_profiler;

  timeunit 1ns;
  timeprecision 1ps;

  import vcache_op_pkg::*;
  import vcache_stat_pkg::*;

  localparam int PHASE_CYCLES = 400;
  // four activity phases plus eight passes over the counters
  localparam int TEST_CYCLES = 10 + 4 * (PHASE_CYCLES + 8) + 8 * `STAT_NUM * 8;

  logic        clk_i;
  logic        reset_i;
  cache_obs_s  cache_obs;
  dma_obs_s    dma_obs;
  fill_obs_s   fill_obs;
  axil_req_s   axil_req;
  axil_rsp_s   axil_rsp;
  logic [31:0] rng_state = 32'he927_fabb;

  vcache_profiler vcache_profiler_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cache_obs_i (cache_obs),
    .dma_obs_i   (dma_obs),
    .fill_obs_i  (fill_obs),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp)
  );

  vcache_prof_checker prof_checker_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cache_obs_i (cache_obs),
    .dma_obs_i   (dma_obs),
    .fill_obs_i  (fill_obs),
    .axil_req_i  (axil_req),
    .axil_rsp_i  (axil_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // population 1, 2 or 4, and 3 now and then
  function automatic logic [3:0] make_mask(input logic [7:0] r);
    case (r[2:0])
      3'd0: return 4'b1110 >> r[3];
      3'd1, 3'd2: return 4'hf;
      3'd3, 3'd4: return r[4] ? 4'b1100 : 4'b0011;
      default: return 4'b0001 << r[5:4];
    endcase
  endfunction

  // kind 0 load, 1 store, else atomic
  function automatic cache_obs_s make_op(input int kind);
    cache_obs_s  c;
    logic [31:0] r;
    r = next_rand();
    c = '0;
    c.v = 1'b1;
    c.yumi = 1'b1;
    c.miss_v = r[0] & r[1];
    c.decode.sigext_op = r[2];
    c.decode.data_size = (r[4:3] == 2'd3) ? 2'd2 : r[4:3];
    if (kind == 0) begin
      c.decode.ld_op = 1'b1;
      c.decode.mask_op = r[5] & r[6]; // masked load, no size class
    end else if (kind == 1) begin
      c.decode.st_op = 1'b1;
      c.decode.mask_op = 1'b1;
      c.mask = make_mask(r[15:8]);
    end else begin
      c.decode.atomic_op = 1'b1;
      c.decode.amo_subop = cache_amo_e'(r[17:16]);
    end
    return c;
  endfunction

  // taken response with no op raises no event
  task automatic drive_quiet();
    cache_obs = '0;
    cache_obs.v = 1'b1;
    cache_obs.yumi = 1'b1;
    dma_obs = '0;
    fill_obs = '0;
  endtask

  task automatic drive_random(input int test);
    logic [31:0] r;
    r = next_rand();
    drive_quiet();
    if (test == 4) begin
      dma_obs = dma_obs_s'(r[2:0]);
      fill_obs.dma_cmd = r[3] ? e_dma_send_fill_addr :
                         (r[6:4] > 3'd4) ? e_dma_nop : dma_cmd_e'(r[6:4]);
      fill_obs.dma_done = r[7];
      fill_obs.chosen_way = r[8 +: `VCACHE_LG_WAYS];
      fill_obs.valid = r[16 +: `VCACHE_WAYS];
      fill_obs.dirty = r[24 +: `VCACHE_WAYS];
    end else if (test == 3) begin
      cache_obs = make_op(2);
      if (r[2:0] == 3'd0) cache_obs.v = 1'b0; // idle or miss cycle
      if (r[2:0] == 3'd1) cache_obs.yumi = 1'b0;
    end else if (r[3:0] != 4'd0) begin
      cache_obs = make_op(int'(r[4]));
    end
  endtask

  task automatic run_phase(input int test);
    for (int n = 0; n < PHASE_CYCLES; n++) begin
      @(posedge clk_i);
      #1;
      drive_random(test);
    end
    @(posedge clk_i);
    #1;
    drive_quiet();
    repeat (4) @(posedge clk_i);
  endtask

  // one read or write with random rready and bready stalls
  task automatic bus_access(input logic is_write, input int addr);
    logic [31:0] r;
    logic        done;
    logic        hs;
    done = 1'b0;
    @(posedge clk_i);
    #1;
    axil_req.arvalid = !is_write;
    axil_req.araddr = addr[`AXIL_ADDR_W-1:0];
    axil_req.awvalid = is_write;
    axil_req.wvalid = is_write;
    axil_req.awaddr = addr[`AXIL_ADDR_W-1:0];
    axil_req.wdata = next_rand();
    while (!done) begin
      r = next_rand();
      axil_req.rready = !is_write && r[1:0] != 2'd0;
      axil_req.bready = is_write && r[1:0] != 2'd0;
      @(posedge clk_i);
      done = is_write ? axil_rsp.bvalid && axil_req.bready : axil_rsp.rvalid && axil_req.rready;
      hs = is_write ? axil_rsp.awready && axil_rsp.wready : axil_rsp.arready;
      #1;
      if (hs) begin
        axil_req.arvalid = 1'b0;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
      end
    end
    axil_req.rready = 1'b0;
    axil_req.bready = 1'b0;
  endtask

  task automatic read_all();
    for (int i = 0; i < `STAT_NUM; i++) begin
      bus_access(1'b0, i * 4);
    end
  endtask

  initial begin
    reset_i = 1'b1;
    axil_req = '0;
    drive_quiet();
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    read_all();
    prof_checker_i.end_test("reset values");
    run_phase(2);
    read_all();
    prof_checker_i.end_test("loads and stores");
    run_phase(3);
    read_all();
    prof_checker_i.end_test("atomics, misses and cycle classes");
    run_phase(4);
    read_all();
    prof_checker_i.end_test("dma and replacement");
    run_phase(2);
    bus_access(1'b1, 'h04); // not the clear register
    bus_access(1'b1, 'h84);
    read_all();
    bus_access(1'b1, `STAT_CLEAR_ADDR);
    read_all();
    for (int a = `STAT_NUM * 4; a < 256; a += 21) begin
      bus_access(1'b0, a);
    end
    prof_checker_i.end_test("clear and bus errors");
    $display("%0d tests, %0d failed, %0d checks, %0d errors", prof_checker_i.tests_run,
             prof_checker_i.tests_failed, prof_checker_i.checks_done, prof_checker_i.err_count);
    if (prof_checker_i.err_count == 0 && prof_checker_i.checks_done > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 4 * 4);
    $display("timeout: the run did not finish within %0d cycles", TEST_CYCLES * 4);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: sim/vcache_prof_checker.sv
// profiler reference model and checker
`include "vcache_prof_defs.svh"

module vcache_prof_checker (
  input logic                       clk_i,
  input logic                       reset_i,
  input vcache_op_pkg::cache_obs_s  cache_obs_i,
  input vcache_op_pkg::dma_obs_s    dma_obs_i,
  input vcache_op_pkg::fill_obs_s   fill_obs_i,
  input vcache_stat_pkg::axil_req_s axil_req_i,
  input vcache_stat_pkg::axil_rsp_s axil_rsp_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import vcache_op_pkg::*;
  import vcache_stat_pkg::*;

  logic [`STAT_CNT_W-1:0] model_cnt [`STAT_NUM];
  logic [`STAT_NUM-1:0]   ev_d1;    // seen last edge, counted this edge
  logic                   clear_d1;
  logic                   rd_pend;  // read response owed
  logic                   wr_pend;  // write response owed
  logic [33:0]            exp_rd_q [$]; // resp above data
  logic [5:0]             exp_idx_q [$];
  axil_resp_e             exp_b_q [$];
  int err_count = 0;
  int checks_done = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int errs_at_start = 0;

  // events one observed cycle should raise
  function automatic logic [`STAT_NUM-1:0] classify(input cache_obs_s c, input dma_obs_s d,
                                                    input fill_obs_s f);
    logic [`STAT_NUM-1:0] e;
    int pop;
    int sz_idx;
    e = '0;
    pop = 0;
    for (int b = 0; b < `VCACHE_MASK_W; b++) begin
      if (c.mask[b]) pop++;
    end
    if (!c.v) begin
      e[c.miss_v ? e_stat_miss_cyc : e_stat_idle_cyc] = 1'b1;
    end else if (!c.yumi) begin
      e[e_stat_stall_rsp_cyc] = 1'b1;
    end else if (c.decode.ld_op) begin
      e[e_stat_ld] = 1'b1;
      e[e_stat_miss_ld] = c.miss_v;
      if (!c.decode.mask_op && c.decode.data_size != 2'd3) begin
        // pairs run signed then unsigned, word first
        sz_idx = int'(e_stat_ld_lb) - 2 * int'(c.decode.data_size) + int'(!c.decode.sigext_op);
        e[stat_idx_e'(sz_idx)] = 1'b1;
      end
    end else if (c.decode.st_op) begin
      e[e_stat_st] = 1'b1;
      e[e_stat_miss_st] = c.miss_v;
      if (c.decode.mask_op && pop == 4) e[e_stat_sm_sw] = 1'b1;
      if (c.decode.mask_op && pop == 2) e[e_stat_sm_sh] = 1'b1;
      if (c.decode.mask_op && pop == 1) e[e_stat_sm_sb] = 1'b1;
    end else if (c.decode.atomic_op) begin
      e[e_stat_atomic] = 1'b1;
      e[e_stat_miss_amo] = c.miss_v;
      if (c.decode.amo_subop != e_amo_other) begin
        e[stat_idx_e'(int'(e_stat_amoswap) + int'(c.decode.amo_subop))] = 1'b1;
      end
    end
    if (d.pkt_v && d.pkt_yumi) e[d.write_not_read ? e_stat_dma_wr : e_stat_dma_rd] = 1'b1;
    if (f.dma_cmd == e_dma_send_fill_addr && f.dma_done) begin
      if (!f.valid[f.chosen_way]) e[e_stat_repl_invalid] = 1'b1;
      else if (f.dirty[f.chosen_way]) e[e_stat_repl_dirty] = 1'b1;
      else e[e_stat_repl_valid] = 1'b1;
    end
    return e;
  endfunction

  always @(posedge clk_i) begin
    logic [5:0]  idx;
    logic        rd_acc;
    logic        wr_acc;
    logic        wr_ok;
    logic [33:0] exp_rd;
    axil_resp_e  exp_b;
    if (reset_i) begin
      foreach (model_cnt[i]) model_cnt[i] = '0;
      ev_d1 = '0;
      clear_d1 = 1'b0;
      rd_pend = 1'b0;
      wr_pend = 1'b0;
    end else begin
      // handshake outputs follow from the responses still owed
      if (axil_rsp_i.rvalid !== rd_pend || axil_rsp_i.arready !== !rd_pend ||
          axil_rsp_i.bvalid !== wr_pend || axil_rsp_i.awready !== !wr_pend ||
          axil_rsp_i.wready !== !wr_pend) begin
        err_count++;
        $display("FAIL %0t ns: handshake rvalid %b arready %b bvalid %b awready %b wready %b",
                 $time, axil_rsp_i.rvalid, axil_rsp_i.arready, axil_rsp_i.bvalid,
                 axil_rsp_i.awready, axil_rsp_i.wready);
      end
      rd_acc = axil_req_i.arvalid && !rd_pend;
      wr_acc = axil_req_i.awvalid && axil_req_i.wvalid && !wr_pend;
      wr_ok = axil_req_i.awaddr == `STAT_CLEAR_ADDR;
      if (rd_pend && axil_req_i.rready) begin
        checks_done++;
        idx = exp_idx_q.pop_front();
        exp_rd = exp_rd_q.pop_front();
        if (axil_rsp_i.rdata !== exp_rd[31:0] || axil_rsp_i.rresp !== exp_rd[33:32]) begin
          err_count++;
          $display("FAIL %0t ns: counter %0d expected %h resp %0d, read %h resp %0d",
                   $time, idx, exp_rd[31:0], exp_rd[33:32], axil_rsp_i.rdata, axil_rsp_i.rresp);
        end
        rd_pend = 1'b0;
      end
      if (wr_pend && axil_req_i.bready) begin
        checks_done++;
        exp_b = exp_b_q.pop_front();
        if (axil_rsp_i.bresp !== exp_b) begin
          err_count++;
          $display("FAIL %0t ns: write resp expected %0d got %0d", $time, exp_b, axil_rsp_i.bresp);
        end
        wr_pend = 1'b0;
      end
      // read data is the count before this edge
      if (rd_acc) begin
        idx = axil_req_i.araddr[`AXIL_ADDR_W-1:2];
        exp_idx_q.push_back(idx);
        if (idx < `STAT_NUM) exp_rd_q.push_back({e_axil_okay, model_cnt[idx[4:0]]});
        else exp_rd_q.push_back({e_axil_slverr, 32'h0});
        rd_pend = 1'b1;
      end
      if (wr_acc) begin
        exp_b_q.push_back(wr_ok ? e_axil_okay : e_axil_slverr);
        wr_pend = 1'b1;
      end
      for (int i = 0; i < `STAT_NUM; i++) begin
        if (clear_d1) model_cnt[i] = '0; // drops events landing with it
        else if (ev_d1[i]) model_cnt[i] = model_cnt[i] + 1;
      end
      clear_d1 = wr_acc && wr_ok;
      ev_d1 = classify(cache_obs_i, dma_obs_i, fill_obs_i);
    end
  end

  task automatic end_test(input string name);
    int errs;
    errs = err_count - errs_at_start;
    errs_at_start = err_count;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errs);
  endtask

endmodule

// File: sources.f
+incdir+rtl
rtl/vcache_op_pkg.sv
rtl/vcache_stat_pkg.sv
rtl/vcache_event_decode.sv
rtl/vcache_stat_counters.sv
rtl/vcache_stat_axil.sv
rtl/vcache_profiler.sv
sim/vcache_prof_checker.sv
sim/tb_vcache_profiler.sv
